// File: src.f
verilog/io_pkg.sv
verilog/io_issue_if.sv
verilog/io_bus_if.sv
verilog/rr_arbiter.sv
verilog/io_thread_issue.sv
verilog/io_request_queue.sv
verilog/io_register_device.sv
verilog/io_subsystem.sv
tests/tb_clock_gen.sv
tests/io_subsystem_tb.sv

// File: Bender.yml
package:
  name: io_subsystem

sources:
  - files:
      - verilog/io_pkg.sv
      - verilog/io_issue_if.sv
      - verilog/io_bus_if.sv
      - verilog/rr_arbiter.sv
      - verilog/io_thread_issue.sv
      - verilog/io_request_queue.sv
      - verilog/io_register_device.sv
      - verilog/io_subsystem.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/io_subsystem_tb.sv

// File: tests/io_subsystem_tb.sv
module io_subsystem_tb;

    localparam int NUM_THREADS = io_pkg::THREADS;
    localparam int NUM_REGS = 16;
    localparam int LATENCY = 3;
    localparam int DIRECTED_CMDS = 12;
    localparam int RANDOM_CMDS = 200;
    localparam int TIMEOUT_CYCLES =
        (DIRECTED_CMDS + RANDOM_CMDS) * (LATENCY + 4 * NUM_THREADS + 10);

    logic clk;
    logic reset;
    logic cmd_valid;
    io_pkg::thread_idx_t cmd_thread;
    logic cmd_store;
    io_pkg::word_t cmd_addr;
    io_pkg::word_t cmd_value;
    logic cmd_ready;
    logic done_valid;
    io_pkg::thread_idx_t done_thread;
    io_pkg::word_t done_value;
    io_pkg::thread_bitmap_t pending;

    // Reference register bank, updated in device acceptance order
    io_pkg::word_t reg_model[NUM_REGS];
    io_pkg::thread_bitmap_t outstanding;
    io_pkg::thread_bitmap_t device_seen;
    io_pkg::thread_bitmap_t rec_store;
    io_pkg::word_t rec_addr[NUM_THREADS];
    io_pkg::word_t rec_value[NUM_THREADS];
    io_pkg::word_t expected_value[NUM_THREADS];

    int mismatch_count;
    int error_count;
    int accepted_count;
    int cycle_count;
    integer seed;
    string test_name;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(5)) clock_gen(.clk(clk), .reset(reset));

    io_subsystem #(
        .NUM_THREADS(NUM_THREADS),
        .NUM_REGS(NUM_REGS),
        .LATENCY(LATENCY)) dut(
        .clk(clk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_thread(cmd_thread),
        .cmd_store(cmd_store),
        .cmd_addr(cmd_addr),
        .cmd_value(cmd_value),
        .cmd_ready(cmd_ready),
        .done_valid(done_valid),
        .done_thread(done_thread),
        .done_value(done_value),
        .pending(pending));

    // Word address above the byte offset, wrapped onto the bank
    function automatic int word_to_register(input io_pkg::word_t addr);
        return int'((addr >> 2) % NUM_REGS);
    endfunction

    task automatic send_command(input int thread, input logic store,
        input io_pkg::word_t addr, input io_pkg::word_t value);
        cmd_valid = 1'b1;
        cmd_thread = io_pkg::thread_idx_t'(thread);
        cmd_store = store;
        cmd_addr = addr;
        cmd_value = value;
        @(negedge clk);
        while (!cmd_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_random_command();
        io_pkg::word_t rnd;
        io_pkg::word_t addr;
        rnd = $random(seed);
        addr = ($random(seed) & ~32'h3f) | (io_pkg::word_t'(int'(rnd[11:8]) % NUM_REGS) << 2);
        send_command(int'(rnd[1:0]) % NUM_THREADS, rnd[4], addr, $random(seed));
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (outstanding != '0)
            @(posedge clk);
        #1;
    endtask

    always @(negedge clk)
    begin
        int t;
        int r;
        if (reset === 1'b0)
        begin
            // Request taken by the device at the coming edge
            if (dut.bus_if.request_valid && dut.bus_if.ready)
            begin
                t = int'(dut.bus_if.request.thread_idx);
                request_open: assert (outstanding[t] && !device_seen[t])
                else
                begin
                    error_count++;
                    $display("Device request for thread %0d without an open command", t);
                end
                r = word_to_register(rec_addr[t]);
                expected_value[t] = rec_store[t] ? rec_value[t] : reg_model[r];
                if (rec_store[t])
                    reg_model[r] = rec_value[t];
                device_seen[t] = 1'b1;
            end
            ready_when_free: assert (!(cmd_ready && outstanding[cmd_thread]))
            else
            begin
                error_count++;
                $display("cmd_ready is high for busy thread %0d", cmd_thread);
            end
            if (done_valid)
            begin
                t = int'(done_thread);
                if (!outstanding[t] || !device_seen[t])
                begin
                    error_count++;
                    $display("Completion on thread %0d without a device access", t);
                end
                else
                begin
                    done_value_check: assert (done_value == expected_value[t])
                    else
                    begin
                        mismatch_count++;
                        $display("Mismatch %s: thread %0d expected %h actual %h",
                            test_name, t, expected_value[t], done_value);
                    end
                end
                outstanding[t] = 1'b0;
                device_seen[t] = 1'b0;
            end
            if (cmd_valid && cmd_ready)
            begin
                t = int'(cmd_thread);
                outstanding[t] = 1'b1;
                rec_store[t] = cmd_store;
                rec_addr[t] = cmd_addr;
                rec_value[t] = cmd_value;
                accepted_count++;
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> cmd_ready && !done_valid && pending == '0)
    else
    begin
        mismatch_count++;
        $display("Mismatch reset_state: expected ready=1 done=0 pending=0 actual %b %b %b",
            $sampled(cmd_ready), $sampled(done_valid), $sampled(pending));
    end

    pending_only_open: assert property (@(posedge clk) disable iff (reset)
        (pending & ~outstanding) == '0)
    else
    begin
        mismatch_count++;
        $display("Mismatch %s: pending expected within %b actual %b",
            test_name, $sampled(outstanding), $sampled(pending));
    end

    // From the grant toward the device until completion
    pending_at_device: assert property (@(posedge clk) disable iff (reset)
        (device_seen & ~pending) == '0)
    else
    begin
        mismatch_count++;
        $display("Mismatch %s: pending expected to cover %b actual %b",
            test_name, $sampled(device_seen), $sampled(pending));
    end

    no_double_done: assert property (@(posedge clk) disable iff (reset)
        done_valid |=> !(done_valid && done_thread == $past(done_thread)))
    else
    begin
        error_count++;
        $display("Thread completed twice in consecutive cycles");
    end

    initial
    begin
        seed = 32'h38fb;
        cmd_valid = 1'b0;
        cmd_thread = '0;
        cmd_store = 1'b0;
        cmd_addr = '0;
        cmd_value = '0;
        outstanding = '0;
        device_seen = '0;
        rec_store = '0;
        mismatch_count = 0;
        error_count = 0;
        accepted_count = 0;
        for (int i = 0; i < NUM_REGS; i++)
            reg_model[i] = '0;
        test_name = "reset_state";
        while (reset !== 1'b0)
            @(posedge clk);
        @(posedge clk);
        #1;
        // Second pair reaches register 5 through a wrapped address
        test_name = "store_load";
        send_command(0, 1'b1, 32'h0000_000c, 32'hcafe_0003);
        send_command(0, 1'b0, 32'h0000_000c, 32'h0);
        send_command(1, 1'b1, 32'h0000_0054, 32'h5a5a_0005);
        send_command(1, 1'b0, 32'h0000_0014, 32'h0);
        wait_idle();
        test_name = "all_threads";
        for (int t = 0; t < NUM_THREADS; t++)
            send_command(t, 1'b1, 32'(t) << 2, 32'h1000_0000 | 32'(t));
        for (int t = 0; t < NUM_THREADS; t++)
            send_command(t, 1'b0, 32'((t + 1) % NUM_THREADS) << 2, 32'h0);
        wait_idle();
        test_name = "random_mix";
        repeat (RANDOM_CMDS)
            send_random_command();
        wait_idle();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("Timeout after %0d cycles with %0d commands accepted",
            cycle_count, accepted_count);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen
    #(parameter PERIOD = 4,
      parameter RESET_CYCLES = 5)
    (output logic clk,
    output logic reset);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after a rising edge, like the other inputs
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: verilog/io_subsystem.sv
module io_subsystem
    #(parameter NUM_THREADS = io_pkg::THREADS,
      parameter NUM_REGS = 16,
      parameter LATENCY = 3)
    (input clk,
    input reset,
    input cmd_valid,
    input io_pkg::thread_idx_t cmd_thread,
    input cmd_store,
    input io_pkg::word_t cmd_addr,
    input io_pkg::word_t cmd_value,
    output logic cmd_ready,
    output logic done_valid,
    output io_pkg::thread_idx_t done_thread,
    output io_pkg::word_t done_value,
    output io_pkg::thread_bitmap_t pending);

    io_issue_if issue_if();
    io_bus_if bus_if();

    io_thread_issue #(.NUM_THREADS(NUM_THREADS)) thread_issue(
        .clk(clk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_thread(cmd_thread),
        .cmd_store(cmd_store),
        .cmd_addr(cmd_addr),
        .cmd_value(cmd_value),
        .cmd_ready(cmd_ready),
        .done_valid(done_valid),
        .done_thread(done_thread),
        .done_value(done_value),
        .issue(issue_if.producer));

    io_request_queue #(.NUM_THREADS(NUM_THREADS)) request_queue(
        .clk(clk),
        .reset(reset),
        .issue(issue_if.queue),
        .bus(bus_if.requester));

    io_register_device #(
        .NUM_REGS(NUM_REGS),
        .LATENCY(LATENCY)) register_device(
        .clk(clk),
        .reset(reset),
        .bus(bus_if.device));

    // Threads with an outstanding device access
    assign pending = issue_if.pending;

endmodule

// File: verilog/io_register_device.sv
module io_register_device
    #(parameter NUM_REGS = 16,
      parameter LATENCY = 3)
    (input clk,
    input reset,
    io_bus_if.device bus);

    localparam CNT_BITS = $clog2(LATENCY + 1);

    io_pkg::word_t regs[NUM_REGS];
    io_pkg::word_t reg_index;
    io_pkg::iorsp_packet_t response_q;
    logic [CNT_BITS-1:0] count;
    logic busy;
    logic accept;

    // Word address, wrapped onto the bank
    assign reg_index = (bus.request.address >> 2) % NUM_REGS;

    assign bus.ready = !busy;
    assign accept = bus.request_valid && bus.ready;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (accept && bus.request.store)
            regs[reg_index] <= bus.request.value;
    end

    // Response is captured at acceptance and held until sent
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            response_q.thread_idx <= bus.request.thread_idx;
            response_q.read_value <= bus.request.store
                ? bus.request.value : regs[reg_index];
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            count <= '0;
        end
        else if (accept)
        begin
            busy <= 1'b1;
            count <= CNT_BITS'(LATENCY);
        end
        else if (busy)
        begin
            if (count == '0)
                busy <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

    assign bus.response_valid = busy && count == '0;
    assign bus.response = response_q;

    no_accept_while_busy: assert property (@(posedge clk) disable iff (reset)
        accept |=> !accept [*LATENCY + 1]);

endmodule

// File: verilog/io_request_queue.sv
module io_request_queue
    #(parameter NUM_THREADS = io_pkg::THREADS)
    (input clk,
    input reset,
    io_issue_if.queue issue,
    io_bus_if.requester bus);

    // One pending access per thread
    io_pkg::thread_bitmap_t entry_valid;
    io_pkg::thread_bitmap_t entry_sent;
    io_pkg::thread_bitmap_t entry_store;
    io_pkg::word_t entry_addr[NUM_THREADS];
    io_pkg::word_t entry_value[NUM_THREADS];

    io_pkg::thread_bitmap_t send_request;
    io_pkg::thread_bitmap_t send_grant_oh;
    io_pkg::thread_idx_t send_grant_idx;
    logic strobe;
    logic first_strobe;
    logic transfer;

    assign strobe = issue.write_en || issue.read_en;
    assign first_strobe = strobe && !entry_valid[issue.thread_idx];
    assign transfer = bus.request_valid && bus.ready;

    assign send_request = entry_valid & ~entry_sent;
    assign issue.pending = (entry_valid & entry_sent) | send_grant_oh;

    // Priority moves only when the device takes a request
    rr_arbiter #(.NUM_REQUESTERS(NUM_THREADS)) request_arbiter(
        .clk(clk),
        .reset(reset),
        .request(send_request),
        .update(transfer),
        .grant_oh(send_grant_oh),
        .grant_idx(send_grant_idx));

    assign bus.request_valid = |send_request;
    assign bus.request.store = entry_store[send_grant_idx];
    assign bus.request.address = entry_addr[send_grant_idx];
    assign bus.request.value = entry_value[send_grant_idx];
    assign bus.request.thread_idx = send_grant_idx;

    // Wake only in the response cycle
    assign issue.wake_bitmap = bus.response_valid
        ? io_pkg::thread_bitmap_t'(1) << bus.response.thread_idx
        : '0;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            entry_valid <= '0;
            entry_sent <= '0;
        end
        else
        begin
            for (int t = 0; t < NUM_THREADS; t++)
            begin
                if (strobe && issue.thread_idx == io_pkg::thread_idx_t'(t))
                begin
                    if (entry_valid[t])
                    begin
                        // Replay completes the access
                        entry_valid[t] <= 1'b0;
                    end
                    else
                    begin
                        entry_valid[t] <= 1'b1;
                        entry_sent[t] <= 1'b0;
                    end
                end
                if (transfer && send_grant_idx == io_pkg::thread_idx_t'(t))
                    entry_sent[t] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (first_strobe)
        begin
            entry_store[issue.thread_idx] <= issue.write_en;
            entry_addr[issue.thread_idx] <= issue.addr;
            entry_value[issue.thread_idx] <= issue.write_value;
        end
        if (bus.response_valid)
            entry_value[bus.response.thread_idx] <= bus.response.read_value;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            issue.rollback_en <= 1'b0;
        else
            issue.rollback_en <= first_strobe;
    end

    // Holds the response value when the strobe is a replay
    always_ff @(posedge clk)
        issue.read_value <= entry_value[issue.thread_idx];

    response_matches_entry: assert property (@(posedge clk) disable iff (reset)
        bus.response_valid |-> entry_valid[bus.response.thread_idx]
            && entry_sent[bus.response.thread_idx]);

endmodule

// File: verilog/io_thread_issue.sv
module io_thread_issue
    #(parameter NUM_THREADS = io_pkg::THREADS)
    (input clk,
    input reset,
    input cmd_valid,
    input io_pkg::thread_idx_t cmd_thread,
    input cmd_store,
    input io_pkg::word_t cmd_addr,
    input io_pkg::word_t cmd_value,
    output logic cmd_ready,
    output logic done_valid,
    output io_pkg::thread_idx_t done_thread,
    output io_pkg::word_t done_value,
    io_issue_if.producer issue);

    // Per-thread command slots
    io_pkg::thread_bitmap_t slot_loaded;
    io_pkg::thread_bitmap_t slot_sleeping;
    io_pkg::thread_bitmap_t slot_store;
    io_pkg::word_t slot_addr[NUM_THREADS];
    io_pkg::word_t slot_value[NUM_THREADS];

    io_pkg::thread_bitmap_t eligible;
    io_pkg::thread_bitmap_t issued_mask;
    io_pkg::thread_bitmap_t grant_oh;
    io_pkg::thread_idx_t grant_idx;
    logic issue_strobe;
    logic cmd_accept;
    logic issued_valid;
    io_pkg::thread_idx_t issued_thread;

    assign cmd_ready = !slot_loaded[cmd_thread];
    assign cmd_accept = cmd_valid && cmd_ready;

    // Last issued thread waits for the queue's verdict
    assign issued_mask = issued_valid ? io_pkg::thread_bitmap_t'(1) << issued_thread : '0;
    assign eligible = slot_loaded & ~slot_sleeping & ~issued_mask;
    assign issue_strobe = |grant_oh;

    rr_arbiter #(.NUM_REQUESTERS(NUM_THREADS)) issue_arbiter(
        .clk(clk),
        .reset(reset),
        .request(eligible),
        .update(issue_strobe),
        .grant_oh(grant_oh),
        .grant_idx(grant_idx));

    assign issue.write_en = issue_strobe && slot_store[grant_idx];
    assign issue.read_en = issue_strobe && !slot_store[grant_idx];
    assign issue.thread_idx = grant_idx;
    assign issue.addr = slot_addr[grant_idx];
    assign issue.write_value = slot_value[grant_idx];

    // No rollback on the issue just seen means the access completed
    assign done_valid = issued_valid && !issue.rollback_en;
    assign done_thread = issued_thread;
    assign done_value = issue.read_value;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            slot_loaded <= '0;
            slot_sleeping <= '0;
            issued_valid <= 1'b0;
            issued_thread <= '0;
        end
        else
        begin
            issued_valid <= issue_strobe;
            issued_thread <= grant_idx;
            for (int t = 0; t < NUM_THREADS; t++)
            begin
                if (issue.wake_bitmap[t])
                    slot_sleeping[t] <= 1'b0;
                else if (issued_valid && issue.rollback_en
                    && issued_thread == io_pkg::thread_idx_t'(t))
                    slot_sleeping[t] <= 1'b1;
            end
            if (done_valid)
                slot_loaded[issued_thread] <= 1'b0;
            if (cmd_accept)
                slot_loaded[cmd_thread] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_accept)
        begin
            slot_store[cmd_thread] <= cmd_store;
            slot_addr[cmd_thread] <= cmd_addr;
            slot_value[cmd_thread] <= cmd_value;
        end
    end

    no_issue_while_asleep: assert property (@(posedge clk) disable iff (reset)
        (issue.write_en || issue.read_en) |-> !slot_sleeping[issue.thread_idx]);

endmodule

// File: verilog/rr_arbiter.sv
module rr_arbiter
    #(parameter NUM_REQUESTERS = 4,
      localparam IDX_WIDTH = NUM_REQUESTERS > 1 ? $clog2(NUM_REQUESTERS) : 1)
    (input clk,
    input reset,
    input [NUM_REQUESTERS-1:0] request,
    input logic update,
    output logic [NUM_REQUESTERS-1:0] grant_oh,
    output logic [IDX_WIDTH-1:0] grant_idx);

    logic [IDX_WIDTH-1:0] last_idx;

    // Search starts just after the previous winner
    always_comb
    begin
        int candidate;
        grant_oh = '0;
        for (int offset = 1; offset <= NUM_REQUESTERS; offset++)
        begin
            candidate = (int'(last_idx) + offset) % NUM_REQUESTERS;
            if (request[candidate] && grant_oh == '0)
                grant_oh[candidate] = 1'b1;
        end
    end

    // One-hot to index
    always_comb
    begin
        grant_idx = '0;
        for (int i = 0; i < NUM_REQUESTERS; i++)
        begin
            if (grant_oh[i])
                grant_idx = grant_idx | IDX_WIDTH'(i);
        end
    end

    // Requester 0 has priority out of reset
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            last_idx <= IDX_WIDTH'(NUM_REQUESTERS - 1);
        else if (update && |request)
            last_idx <= grant_idx;
    end

    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_oh));

endmodule

// File: verilog/io_bus_if.sv
interface io_bus_if;

    // Request channel, transfers when valid and ready are both high
    logic request_valid;
    io_pkg::ioreq_packet_t request;
    logic ready;

    // Response channel, one cycle per transaction
    logic response_valid;
    io_pkg::iorsp_packet_t response;

    modport requester(
        output request_valid, request,
        input ready, response_valid, response);

    modport device(
        input request_valid, request,
        output ready, response_valid, response);

endinterface

// File: verilog/io_issue_if.sv
interface io_issue_if;

    // Issue strobe and access fields
    logic write_en;
    logic read_en;
    io_pkg::thread_idx_t thread_idx;
    io_pkg::word_t addr;
    io_pkg::word_t write_value;

    // Returned by the request queue
    logic rollback_en;
    io_pkg::word_t read_value;
    io_pkg::thread_bitmap_t pending;
    io_pkg::thread_bitmap_t wake_bitmap;

    modport producer(
        output write_en, read_en, thread_idx, addr, write_value,
        input rollback_en, read_value, wake_bitmap);

    modport queue(
        input write_en, read_en, thread_idx, addr, write_value,
        output rollback_en, read_value, pending, wake_bitmap);

endinterface

// File: verilog/io_pkg.sv
package io_pkg;

    // Default thread count for the module parameters
    parameter int THREADS = 4;

    // Data and address word
    typedef logic [31:0] word_t;

    // Thread number within the core
    typedef logic [$clog2(THREADS)-1:0] thread_idx_t;

    // One bit per hardware thread
    typedef logic [THREADS-1:0] thread_bitmap_t;

    // Request toward the register device
    typedef struct packed {
        logic store;
        word_t address;
        word_t value;
        thread_idx_t thread_idx;
    } ioreq_packet_t;

    // Response back to the request queue
    typedef struct packed {
        thread_idx_t thread_idx;
        word_t read_value;
    } iorsp_packet_t;

endpackage
